/* common/vectorAluPkg.sv */
`default_nettype none

package vectorAluPkg;

    // register word width with bit 0 as the msb
    localparam int dataWidth = 64;

    // even or odd lanes gathered for the multipliers
    localparam int multWidth = dataWidth / 2;

    typedef logic [0:dataWidth-1] word_t;
    typedef logic [0:1]           laneMode_t;   // ww field
    typedef logic [0:5]           funcCode_t;
    typedef logic [0:multWidth-1] multOperand_t;

    // lane widths selected by ww
    localparam laneMode_t modeByte  = 2'd0;
    localparam laneMode_t modeHalf  = 2'd1;
    localparam laneMode_t modeWord  = 2'd2;
    localparam laneMode_t modeDword = 2'd3;

    // bitwise and move
    localparam funcCode_t fnAnd     = 6'd1;
    localparam funcCode_t fnOr      = 6'd2;
    localparam funcCode_t fnXor     = 6'd3;
    localparam funcCode_t fnNot     = 6'd4;
    localparam funcCode_t fnMov     = 6'd5;

    // lane arithmetic
    localparam funcCode_t fnAdd     = 6'd6;
    localparam funcCode_t fnSub     = 6'd7;
    localparam funcCode_t fnMulEven = 6'd8;
    localparam funcCode_t fnMulOdd  = 6'd9;

    // shifts and rotate
    localparam funcCode_t fnSll     = 6'd10;
    localparam funcCode_t fnSrl     = 6'd11;
    localparam funcCode_t fnSra     = 6'd12;
    localparam funcCode_t fnRotHalf = 6'd13;

    // codes 14 and 15 are free
    localparam funcCode_t fnSqEven  = 6'd16;
    localparam funcCode_t fnSqOdd   = 6'd17;
    // code 18 is free

    // one operation as presented to the execute stage
    typedef struct packed {
        word_t     rA;
        word_t     rB;
        funcCode_t func;
        laneMode_t ww;
    } aluReq_t;

endpackage

`default_nettype wire

/* source/laneArith.sv */
`timescale 1ns/1ps
`default_nettype none

module laneArith (
    input  wire vectorAluPkg::aluReq_t req,
    output vectorAluPkg::word_t        laneResult
);
    import vectorAluPkg::*;

    localparam int modeCount = 4;  // byte, half, word, dword
    localparam int minLaneW  = 8;
    localparam int minAmtW   = 3;  // log2 of a byte lane

    // one result word per lane width, indexed by ww
    word_t sumRes [modeCount];
    word_t difRes [modeCount];
    word_t sllRes [modeCount];
    word_t srlRes [modeCount];
    word_t sraRes [modeCount];
    word_t rotRes [modeCount];

    generate
        for (genvar m = 0; m < modeCount; m++) begin : genMode
            localparam int laneW     = minLaneW << m;
            localparam int amtW      = minAmtW + m;
            localparam int halfW     = laneW / 2;
            localparam int laneCount = dataWidth / laneW;

            for (genvar l = 0; l < laneCount; l++) begin : genLane
                localparam int base = l * laneW;  // msb of this lane

                logic [0:laneW-1] opA;
                logic [0:laneW-1] opB;
                logic [0:amtW-1]  amt;

                assign opA = req.rA[base +: laneW];
                assign opB = req.rB[base +: laneW];
                assign amt = opB[laneW-amtW +: amtW];  // low bits of the rB lane

                // wraps within the lane
                assign sumRes[m][base +: laneW] = opA + opB;
                assign difRes[m][base +: laneW] = opA - opB;

                assign sllRes[m][base +: laneW] = opA << amt;
                assign srlRes[m][base +: laneW] = opA >> amt;
                assign sraRes[m][base +: laneW] = $signed(opA) >>> amt;  // bit 0 is sign

                // swap upper and lower half
                assign rotRes[m][base +: laneW] = {opA[halfW +: halfW], opA[0 +: halfW]};
            end
        end
    endgenerate

    always_comb begin
        case (req.func)
            fnAnd: begin
                laneResult = req.rA & req.rB;
            end
            fnOr: begin
                laneResult = req.rA | req.rB;
            end
            fnXor: begin
                laneResult = req.rA ^ req.rB;
            end
            fnNot: begin
                laneResult = ~req.rA;
            end
            fnMov: begin
                laneResult = req.rA;
            end
            fnAdd: begin
                laneResult = sumRes[req.ww];
            end
            fnSub: begin
                laneResult = difRes[req.ww];
            end
            fnSll: begin
                laneResult = sllRes[req.ww];
            end
            fnSrl: begin
                laneResult = srlRes[req.ww];
            end
            fnSra: begin
                laneResult = sraRes[req.ww];
            end
            fnRotHalf: begin
                laneResult = rotRes[req.ww];
            end
            default: begin
                laneResult = req.rA;  // multiply class and unassigned codes
            end
        endcase
    end

endmodule

`default_nettype wire

/* multiply/laneMultiplier.sv */
`timescale 1ns/1ps
`default_nettype none

module laneMultiplier (
    input  wire vectorAluPkg::aluReq_t req,
    output vectorAluPkg::word_t        product
);
    import vectorAluPkg::*;

    localparam int byteW     = 8;
    localparam int halfW     = 16;
    localparam int wordW     = 32;
    localparam int byteLanes = multWidth / byteW;  // gathered lanes per operand
    localparam int halfLanes = multWidth / halfW;

    logic         oddSel;
    logic         squareSel;
    word_t        srcB;
    multOperand_t multInA;
    multOperand_t multInB;
    word_t        productB;
    word_t        productH;
    word_t        productW;

    assign oddSel    = (req.func == fnMulOdd) || (req.func == fnSqOdd);
    assign squareSel = (req.func == fnSqEven) || (req.func == fnSqOdd);
    assign srcB      = squareSel ? req.rA : req.rB;  // squares reuse rA

    // even lanes count from bit 0, odd ones sit right after them
    always_comb begin
        multInA = '0;
        multInB = '0;
        case (req.ww)
            modeByte: begin
                for (int i = 0; i < byteLanes; i++) begin
                    multInA[i*byteW +: byteW] = req.rA[(2*i + int'(oddSel))*byteW +: byteW];
                    multInB[i*byteW +: byteW] = srcB[(2*i + int'(oddSel))*byteW +: byteW];
                end
            end
            modeHalf: begin
                for (int i = 0; i < halfLanes; i++) begin
                    multInA[i*halfW +: halfW] = req.rA[(2*i + int'(oddSel))*halfW +: halfW];
                    multInB[i*halfW +: halfW] = srcB[(2*i + int'(oddSel))*halfW +: halfW];
                end
            end
            modeWord: begin
                multInA = req.rA[int'(oddSel)*wordW +: wordW];
                multInB = srcB[int'(oddSel)*wordW +: wordW];
            end
            default: begin
                multInA = '0;  // dword has no multiply
                multInB = '0;
            end
        endcase
    end

    // each product is twice the input lane
    generate
        for (genvar i = 0; i < byteLanes; i++) begin : genByteMul
            assign productB[i*2*byteW +: 2*byteW] =
                multInA[i*byteW +: byteW] * multInB[i*byteW +: byteW];
        end

        for (genvar i = 0; i < halfLanes; i++) begin : genHalfMul
            assign productH[i*2*halfW +: 2*halfW] =
                multInA[i*halfW +: halfW] * multInB[i*halfW +: halfW];
        end
    endgenerate

    assign productW = multInA * multInB;  // full 64 bit result

    always_comb begin
        case (req.ww)
            modeByte: begin
                product = productB;
            end
            modeHalf: begin
                product = productH;
            end
            modeWord: begin
                product = productW;
            end
            default: begin
                product = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* source/resultSelect.sv */
`timescale 1ns/1ps
`default_nettype none

module resultSelect (
    input  wire                          clk,
    input  wire                          rstN,
    input  wire vectorAluPkg::funcCode_t func,
    input  wire vectorAluPkg::word_t     laneResult,
    input  wire vectorAluPkg::word_t     product,
    output vectorAluPkg::word_t          rD
);
    import vectorAluPkg::*;

    logic  multSel;
    word_t nextRd;

    // multiply and square take the product
    always_comb begin
        case (func)
            fnMulEven, fnMulOdd, fnSqEven, fnSqOdd: begin
                multSel = 1'b1;
            end
            default: begin
                multSel = 1'b0;
            end
        endcase
    end

    assign nextRd = multSel ? product : laneResult;

    // execute to writeback boundary
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            rD <= '0;
        end else begin
            rD <= nextRd;  // new result every cycle
        end
    end

endmodule

`default_nettype wire

/* source/vectorAlu.sv */
`timescale 1ns/1ps
`default_nettype none

module vectorAlu (
    input  wire                        clk,
    input  wire                        rstN,
    input  wire vectorAluPkg::aluReq_t req,
    output vectorAluPkg::word_t        rD
);
    import vectorAluPkg::*;

    word_t laneResult;  // logic, add, shift, rotate
    word_t product;     // multiply and square

    laneArith laneArith0 (
        .req        (req),
        .laneResult (laneResult)
    );

    laneMultiplier laneMultiplier0 (
        .req     (req),
        .product (product)
    );

    resultSelect resultSelect0 (
        .clk        (clk),
        .rstN       (rstN),
        .func       (req.func),
        .laneResult (laneResult),
        .product    (product),
        .rD         (rD)
    );

endmodule

`default_nettype wire

/* bench/vectorAluTb.sv */
`timescale 1ns/1ps
`default_nettype none

module vectorAluTb;
    import vectorAluPkg::*;

    localparam int clkPeriod    = 8;
    localparam int resetCycles  = 5;
    localparam int directedOps  = 90;   // rough count of directed operations
    localparam int streamOps    = 200;
    localparam int marginCycles = 100;

    logic    clk;
    logic    rstN;
    aluReq_t req;
    word_t   rD;

    logic [31:0] lfsrState;
    int          errCount;
    int          testsRun;
    int          testsFailed;
    int          testErrStart;

    vectorAlu dut0 (
        .clk  (clk),
        .rstN (rstN),
        .req  (req),
        .rD   (rD)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    initial begin
        #((resetCycles + directedOps + streamOps + marginCycles) * clkPeriod);
        $display("watchdog expired, the run stopped making progress");
        $display("Test failures found");
        $finish;
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] nextLfsr(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [63:0] randomBits(int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = nextLfsr(lfsrState);
            v = {v[62:0], lfsrState[0]};
        end
        return v;
    endfunction

    function automatic logic [63:0] laneMask(int w);
        if (w >= 64) begin
            return '1;
        end
        return (64'd1 << w) - 64'd1;
    endfunction

    // lane idx counted from the msb which is bit 0 of word_t
    function automatic logic [63:0] getLane(logic [63:0] v, int idx, int w);
        return (v >> (64 - (idx + 1) * w)) & laneMask(w);
    endfunction

    function automatic logic [63:0] putLane(logic [63:0] lane, int idx, int w);
        return (lane & laneMask(w)) << (64 - (idx + 1) * w);
    endfunction

    function automatic aluReq_t makeReq(funcCode_t f, laneMode_t m, word_t a, word_t b);
        aluReq_t r;
        r.rA   = a;
        r.rB   = b;
        r.func = f;
        r.ww   = m;
        return r;
    endfunction

    // reference model on a [63:0] copy so lane 0 sits at the top
    function automatic word_t expected(aluReq_t r);
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] srcB;
        logic [63:0] res;
        logic [63:0] la;
        logic [63:0] lb;
        logic [63:0] lr;
        logic [63:0] mask;
        int          w;
        int          lanes;
        int          amt;
        int          idx;
        logic        odd;
        a     = r.rA;
        b     = r.rB;
        res   = '0;
        w     = 8 << r.ww;
        lanes = 64 / w;
        mask  = laneMask(w);
        odd   = (r.func == fnMulOdd) || (r.func == fnSqOdd);
        srcB  = ((r.func == fnSqEven) || (r.func == fnSqOdd)) ? a : b;
        case (r.func)
            fnAnd: res = a & b;
            fnOr:  res = a | b;
            fnXor: res = a ^ b;
            fnNot: res = ~a;
            fnMov: res = a;
            fnAdd, fnSub, fnSll, fnSrl, fnSra, fnRotHalf: begin
                for (int l = 0; l < lanes; l++) begin
                    la  = getLane(a, l, w);
                    lb  = getLane(b, l, w);
                    amt = int'(lb & (w - 1));  // low log2(w) bits
                    case (r.func)
                        fnAdd: lr = la + lb;
                        fnSub: lr = la - lb;
                        fnSll: lr = la << amt;
                        fnSrl: lr = la >> amt;
                        fnSra: begin
                            lr = la >> amt;
                            if (la[w-1]) begin
                                lr = lr | (mask & ~(mask >> amt));  // sign fill
                            end
                        end
                        default: lr = (la << (w / 2)) | (la >> (w / 2));
                    endcase
                    res = res | putLane(lr, l, w);
                end
            end
            fnMulEven, fnMulOdd, fnSqEven, fnSqOdd: begin
                if (r.ww != modeDword) begin
                    for (int i = 0; i < lanes / 2; i++) begin
                        idx = 2 * i + (odd ? 1 : 0);
                        lr  = getLane(a, idx, w) * getLane(srcB, idx, w);
                        res = res | putLane(lr, i, 2 * w);
                    end
                end
            end
            default: res = a;  // unassigned codes
        endcase
        return res;
    endfunction

    task automatic checkWord(string name, word_t exp, word_t act);
        if (act !== exp) begin
            errCount++;
            $display("ERR %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic checkReset(word_t act);
        if (act !== '0) begin
            errCount++;
            $display("ERR reset expected %h actual %h", word_t'(0), act);
        end
    endtask

    // called on a falling edge, returns on the next one
    task automatic runOp(string name, aluReq_t r, word_t exp);
        req = r;
        @(negedge clk);
        checkWord(name, exp, rD);
    endtask

    task automatic runModel(string name, aluReq_t r);
        runOp(name, r, expected(r));
    endtask

    task automatic startTest();
        testErrStart = errCount;
    endtask

    task automatic endTest(string name);
        testsRun++;
        if (errCount != testErrStart) begin
            testsFailed++;
            $display("test %s FAILED with %0d errors", name, errCount - testErrStart);
        end else begin
            $display("test %s ok", name);
        end
    endtask

    localparam word_t patA   = 64'h0123_4567_89ab_cdef;
    localparam word_t patB   = 64'hf0e1_d2c3_b4a5_9687;
    localparam word_t ones   = '1;
    localparam word_t shiftA = 64'h80f1_4c7e_a5c3_9e01;  // several lanes with msb set
    localparam word_t shiftB = 64'h0102_0304_0507_060d;

    task automatic testResetLogic();
        int freeCodes [5] = '{0, 14, 15, 18, 63};
        startTest();
        req = makeReq(fnMov, modeByte, patA, patB);  // nonzero result held off by reset
        repeat (resetCycles) @(negedge clk);
        checkReset(rD);
        rstN = 1'b1;
        runOp("and", makeReq(fnAnd, modeByte, patA, patB), patA & patB);
        runOp("or", makeReq(fnOr, modeHalf, patA, patB), patA | patB);
        runOp("xor", makeReq(fnXor, modeWord, patA, patB), patA ^ patB);
        runOp("not", makeReq(fnNot, modeDword, patA, patB), ~patA);
        runOp("mov", makeReq(fnMov, modeByte, patB, patA), patB);
        foreach (freeCodes[i]) begin
            runOp($sformatf("free code %0d", freeCodes[i]),
                  makeReq(funcCode_t'(freeCodes[i]), modeHalf, patB, patA), patB);
        end
        endTest("reset and logic");
    endtask

    task automatic testAddSub();
        startTest();
        for (int m = 0; m < 4; m++) begin
            runModel($sformatf("add ww%0d", m), makeReq(fnAdd, laneMode_t'(m), patA, patB));
            runModel($sformatf("sub ww%0d", m), makeReq(fnSub, laneMode_t'(m), patA, patB));
            runModel($sformatf("add ones ww%0d", m), makeReq(fnAdd, laneMode_t'(m), ones, patA));
            runModel($sformatf("sub zero ww%0d", m), makeReq(fnSub, laneMode_t'(m), '0, patB));
        end
        // carry stays in the lane except for dword
        runOp("add byte wrap", makeReq(fnAdd, modeByte, 64'hff, 64'h1), 64'h0);
        runOp("add dword carry", makeReq(fnAdd, modeDword, 64'hff, 64'h1), 64'h100);
        runOp("add byte ones", makeReq(fnAdd, modeByte, ones, 64'h0101_0101_0101_0101), 64'h0);
        runOp("sub half wrap", makeReq(fnSub, modeHalf, 64'h0, 64'h1), 64'h0000_0000_0000_ffff);
        endTest("add and subtract");
    endtask

    task automatic testShifts();
        funcCode_t codes [3] = '{fnSll, fnSrl, fnSra};
        startTest();
        for (int m = 0; m < 4; m++) begin
            foreach (codes[c]) begin
                runModel($sformatf("shift code %0d ww%0d", codes[c], m),
                         makeReq(codes[c], laneMode_t'(m), shiftA, shiftB));
            end
        end
        runOp("sra byte fill", makeReq(fnSra, modeByte, 64'h807f_8001_ff00_c040,
              64'h0707_0707_0707_0707), 64'hff00_ff00_ff00_ff00);
        endTest("shifts");
    endtask

    task automatic testRotate();
        startTest();
        for (int m = 0; m < 4; m++) begin
            runModel($sformatf("rot ww%0d", m), makeReq(fnRotHalf, laneMode_t'(m), patA, patB));
        end
        runOp("rot byte nibbles", makeReq(fnRotHalf, modeByte, patA, patB),
              64'h1032_5476_98ba_dcfe);
        endTest("rotate");
    endtask

    task automatic testMultiply();
        funcCode_t codes [4] = '{fnMulEven, fnMulOdd, fnSqEven, fnSqOdd};
        startTest();
        for (int m = 0; m < 3; m++) begin
            foreach (codes[c]) begin
                runModel($sformatf("mul code %0d ww%0d", codes[c], m),
                         makeReq(codes[c], laneMode_t'(m), patA, patB));
                runModel($sformatf("mul ones code %0d ww%0d", codes[c], m),
                         makeReq(codes[c], laneMode_t'(m), ones, patB));
            end
        end
        runOp("sq byte ones", makeReq(fnSqEven, modeByte, ones, '0), 64'hfe01_fe01_fe01_fe01);
        runOp("sq half ones", makeReq(fnSqOdd, modeHalf, ones, '0), 64'hfffe_0001_fffe_0001);
        runOp("sq word ones", makeReq(fnSqEven, modeWord, ones, '0), 64'hffff_fffe_0000_0001);
        foreach (codes[c]) begin
            runOp($sformatf("mul dword code %0d", codes[c]),
                  makeReq(codes[c], modeDword, patA, patB), 64'h0);
        end
        endTest("multiply and square");
    endtask

    task automatic testStream();
        funcCode_t codes [15] = '{fnAnd, fnOr, fnXor, fnNot, fnMov, fnAdd, fnSub, fnMulEven,
                                  fnMulOdd, fnSll, fnSrl, fnSra, fnRotHalf, fnSqEven, fnSqOdd};
        aluReq_t   r;
        startTest();
        for (int i = 0; i < streamOps; i++) begin
            r.func = codes[int'(randomBits(8)) % 15];
            r.ww   = laneMode_t'(randomBits(2));
            r.rA   = randomBits(64);
            r.rB   = randomBits(64);
            runModel($sformatf("stream op %0d", i), r);  // one per cycle
        end
        endTest("back-to-back stream");
    endtask

    initial begin
        rstN         = 1'b0;
        req          = '0;
        lfsrState    = 32'hee84_e6fa;
        errCount     = 0;
        testsRun     = 0;
        testsFailed  = 0;
        testErrStart = 0;

        testResetLogic();
        testAddSub();
        testShifts();
        testRotate();
        testMultiply();
        testStream();

        $display("tests run %0d, tests failed %0d, check errors %0d",
                 testsRun, testsFailed, errCount);
        if (errCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
common/vectorAluPkg.sv
source/laneArith.sv
multiply/laneMultiplier.sv
source/resultSelect.sv
source/vectorAlu.sv
bench/vectorAluTb.sv

/* Bender.yml */
package:
  name: vector_alu

sources:
  # package first, then the units, then the top level
  - common/vectorAluPkg.sv
  - source/laneArith.sv
  - multiply/laneMultiplier.sv
  - source/resultSelect.sv
  - source/vectorAlu.sv

  - target: test
    files:
      - bench/vectorAluTb.sv
